/* source/translator_pkg.sv */
package translator_pkg;

   // ------------------------------------------------------------------------
   // widths of the word-addressed master side
   // ------------------------------------------------------------------------
   localparam int AV_ADDRESS_W    = 32;
   localparam int AV_DATA_W       = 32;
   localparam int AV_BURSTCOUNT_W = 4;

   // bytes per word and the address bits they occupy
   localparam int SYMBOLS_PER_WORD = 4;
   localparam int BITS_PER_WORD    = 2;

   // ------------------------------------------------------------------------
   // widths of the byte-addressed universal side
   // ------------------------------------------------------------------------
   localparam int UAV_ADDRESS_W    = AV_ADDRESS_W + BITS_PER_WORD;
   localparam int UAV_BURSTCOUNT_W = AV_BURSTCOUNT_W + BITS_PER_WORD;

   typedef logic [AV_ADDRESS_W-1:0]     av_addr_t;
   typedef logic [UAV_ADDRESS_W-1:0]    uav_addr_t;
   typedef logic [AV_DATA_W-1:0]        data_t;
   typedef logic [SYMBOLS_PER_WORD-1:0] byteen_t;
   typedef logic [AV_BURSTCOUNT_W-1:0]  av_burst_t;
   typedef logic [UAV_BURSTCOUNT_W-1:0] uav_burst_t;

   // transfer phase
   // open: this cycle is the first one of a transfer
   // held: the transfer started earlier and is still stalled
   typedef enum logic {
      xfer_open = 1'b0,
      xfer_held = 1'b1
   } xfer_phase_t;

   // write burst phase
   // first: the next write beat opens a burst
   // inside: a write burst is in progress
   typedef enum logic {
      burst_first  = 1'b0,
      burst_inside = 1'b1
   } burst_phase_t;

endpackage

/* source/transfer_framer.sv */
`timescale 1ns/1ps

module transfer_framer
   import translator_pkg::*;
(
   input  logic      clk,
   input  logic      reset,

   // master side
   input  logic      av_read,
   input  logic      av_write,
   input  data_t     av_writedata,
   input  byteen_t   av_byteenable,
   input  av_addr_t  av_address,
   input  av_burst_t av_burstcount,
   output logic      av_waitrequest,
   output logic      av_readdatavalid,
   output data_t     av_readdata,

   // universal side
   input  logic      uav_waitrequest,
   input  logic      uav_readdatavalid,
   input  data_t     uav_readdata,
   output logic      uav_read,
   output logic      uav_write,
   output data_t     uav_writedata,
   output byteen_t   uav_byteenable,

   // beat tracking
   input  logic      last_beat,
   output logic      begin_xfer,
   output logic      begin_burst
);

   xfer_phase_t  xfer_phase;
   burst_phase_t burst_phase;
   logic         write_accepted;

   // ------------------------------------------------------------------------
   // pass-through paths
   // ------------------------------------------------------------------------
   assign uav_read         = av_read;
   assign uav_write        = av_write;
   assign uav_writedata    = av_writedata;
   assign uav_byteenable   = av_byteenable;

   assign av_readdata      = uav_readdata;
   assign av_readdatavalid = uav_readdatavalid;

   // zero waitrequest allowance, the stall goes straight back
   assign av_waitrequest   = uav_waitrequest;

   assign write_accepted   = uav_write && !uav_waitrequest;

   // ------------------------------------------------------------------------
   // first cycle of a transfer
   // ------------------------------------------------------------------------
   assign begin_xfer = (uav_read || uav_write) && (xfer_phase == xfer_open);

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         xfer_phase <= xfer_open;
      end else if (begin_xfer && uav_waitrequest) begin
         xfer_phase <= xfer_held;
      end else if (!uav_waitrequest) begin
         xfer_phase <= xfer_open;
      end
   end

   // ------------------------------------------------------------------------
   // first beat of a burst
   // ------------------------------------------------------------------------
   // every read is a burst of its own, writes open one only from burst_first
   always_comb begin
      if (uav_read) begin
         begin_burst = begin_xfer;
      end else begin
         begin_burst = begin_xfer && (burst_phase == burst_first);
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         burst_phase <= burst_first;
      end else if (uav_read) begin
         burst_phase <= burst_first;
      end else if (write_accepted && last_beat) begin
         burst_phase <= burst_first;
      end else if (uav_write && begin_xfer) begin
         burst_phase <= burst_inside;
      end
   end

   // master must hold its request steady across a stall
   property p_master_stable;
      @(posedge clk) disable iff (reset)
         (av_waitrequest && (av_read || av_write)) |=>
            ($stable(av_address) && $stable(av_burstcount) &&
             $stable(av_byteenable) && $stable(av_read) && $stable(av_write));
   endproperty

   a_master_stable : assert property (p_master_stable)
      else $error("transfer_framer: master changed its request while stalled");

endmodule

/* source/beat_address.sv */
`timescale 1ns/1ps

module beat_address
   import translator_pkg::*;
(
   input  logic      clk,
   input  logic      reset,

   // master side word address
   input  av_addr_t  av_address,

   // control from the framer
   input  logic      uav_write,
   input  logic      av_waitrequest,
   input  logic      begin_burst,

   // byte address towards the universal side
   output uav_addr_t uav_address
);

   // ------------------------------------------------------------------------
   // word to byte address conversion
   // ------------------------------------------------------------------------
   uav_addr_t converted_address;
   uav_addr_t address_register;
   uav_addr_t selected_address;

   // low address bits are zero for word-aligned accesses
   always_comb begin
      converted_address = {av_address, {BITS_PER_WORD{1'b0}}};
   end

   // first beat of a burst takes the master address directly,
   // later beats take the stepped register
   always_comb begin
      if (begin_burst) begin
         selected_address = converted_address;
      end else begin
         selected_address = address_register;
      end
   end

   assign uav_address = selected_address;

   // ------------------------------------------------------------------------
   // per-beat address register
   // ------------------------------------------------------------------------
   // a stall reloads whatever is on the output so it stays put;
   // an accepted write beat moves on to the next word
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         address_register <= '0;
      end else if (av_waitrequest) begin
         address_register <= selected_address;
      end else if (uav_write) begin
         address_register <= selected_address + uav_addr_t'(SYMBOLS_PER_WORD);
      end
   end

   // reads leave the register alone, the next write burst
   // reloads it through begin_burst anyway

endmodule

/* source/burst_counter.sv */
`timescale 1ns/1ps

module burst_counter
   import translator_pkg::*;
(
   input  logic       clk,
   input  logic       reset,

   // master side burst length in words
   input  av_burst_t  av_burstcount,

   // control from the framer
   input  logic       av_waitrequest,
   input  logic       begin_xfer,
   input  logic       begin_burst,

   // byte count towards the universal side
   output uav_burst_t uav_burstcount,
   output logic       last_beat
);

   // ------------------------------------------------------------------------
   // remaining word count
   // ------------------------------------------------------------------------
   av_burst_t remaining_words;
   logic      first_burst_stalled;
   logic      burst_stalled;
   logic      last_beat_incoming;
   logic      last_beat_registered;

   // first beat loads the full length, or the length minus the beat
   // that was just accepted
   always_ff @(posedge clk) begin
      if (begin_burst || first_burst_stalled) begin
         if (av_waitrequest) begin
            remaining_words <= av_burstcount;
         end else begin
            remaining_words <= av_burstcount - av_burst_t'(1);
         end
      end else if (begin_xfer || burst_stalled) begin
         // later beats count down once they are accepted
         if (!av_waitrequest) begin
            remaining_words <= remaining_words - av_burst_t'(1);
         end
      end
   end

   // ------------------------------------------------------------------------
   // stall tracking
   // ------------------------------------------------------------------------
   // first_burst_stalled keeps the load path open while the first beat waits,
   // burst_stalled does the same for the decrement of a later beat
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         first_burst_stalled <= 1'b0;
         burst_stalled       <= 1'b0;
      end else if (begin_burst || first_burst_stalled) begin
         first_burst_stalled <= av_waitrequest;
      end else if (begin_xfer || burst_stalled) begin
         burst_stalled <= av_waitrequest;
      end
   end

   // ------------------------------------------------------------------------
   // outputs
   // ------------------------------------------------------------------------
   // both compares sit ahead of the select to keep them off the mux path
   assign last_beat_incoming   = (av_burstcount == av_burst_t'(1));
   assign last_beat_registered = (remaining_words == av_burst_t'(1));

   always_comb begin
      if (begin_burst) begin
         uav_burstcount = {av_burstcount, {BITS_PER_WORD{1'b0}}};
         last_beat      = last_beat_incoming;
      end else begin
         uav_burstcount = {remaining_words, {BITS_PER_WORD{1'b0}}};
         last_beat      = last_beat_registered;
      end
   end

   // a beat that opens a transfer without opening a burst belongs to a
   // write burst already under way, so some words must still be owed
   property p_remaining_nonzero;
      @(posedge clk) disable iff (reset)
         (begin_xfer && !begin_burst) |-> (remaining_words != '0);
   endproperty

   a_remaining_nonzero : assert property (p_remaining_nonzero)
      else $error("burst_counter: write beat inside a burst with no words left");

endmodule

/* source/master_translator.sv */
`timescale 1ns/1ps

module master_translator
   import translator_pkg::*;
(
   input  logic       clk,
   input  logic       reset,

   // ------------------------------------------------------------------------
   // word-addressed master port
   // ------------------------------------------------------------------------
   input  logic       av_read,
   input  logic       av_write,
   input  av_addr_t   av_address,
   input  av_burst_t  av_burstcount,
   input  byteen_t    av_byteenable,
   input  data_t      av_writedata,
   output data_t      av_readdata,
   output logic       av_readdatavalid,
   output logic       av_waitrequest,

   // ------------------------------------------------------------------------
   // byte-addressed universal port
   // ------------------------------------------------------------------------
   output logic       uav_read,
   output logic       uav_write,
   output uav_addr_t  uav_address,
   output uav_burst_t uav_burstcount,
   output byteen_t    uav_byteenable,
   output data_t      uav_writedata,
   input  data_t      uav_readdata,
   input  logic       uav_readdatavalid,
   input  logic       uav_waitrequest
);

   // beat tracking between the three blocks
   logic begin_xfer;
   logic begin_burst;
   logic last_beat;

   // controls, pass-through and phase tracking
   transfer_framer u_transfer_framer (
      .clk               (clk),
      .reset             (reset),
      .av_read           (av_read),
      .av_write          (av_write),
      .av_writedata      (av_writedata),
      .av_byteenable     (av_byteenable),
      .av_address        (av_address),
      .av_burstcount     (av_burstcount),
      .av_waitrequest    (av_waitrequest),
      .av_readdatavalid  (av_readdatavalid),
      .av_readdata       (av_readdata),
      .uav_waitrequest   (uav_waitrequest),
      .uav_readdatavalid (uav_readdatavalid),
      .uav_readdata      (uav_readdata),
      .uav_read          (uav_read),
      .uav_write         (uav_write),
      .uav_writedata     (uav_writedata),
      .uav_byteenable    (uav_byteenable),
      .last_beat         (last_beat),
      .begin_xfer        (begin_xfer),
      .begin_burst       (begin_burst)
   );

   // per-beat byte address
   beat_address u_beat_address (
      .clk            (clk),
      .reset          (reset),
      .av_address     (av_address),
      .uav_write      (uav_write),
      .av_waitrequest (av_waitrequest),
      .begin_burst    (begin_burst),
      .uav_address    (uav_address)
   );

   // remaining byte count and last-beat detection
   burst_counter u_burst_counter (
      .clk            (clk),
      .reset          (reset),
      .av_burstcount  (av_burstcount),
      .av_waitrequest (av_waitrequest),
      .begin_xfer     (begin_xfer),
      .begin_burst    (begin_burst),
      .uav_burstcount (uav_burstcount),
      .last_beat      (last_beat)
   );

endmodule

/* verif/tb_slave_model.sv */
`timescale 1ns/1ps

module tb_slave_model
   import translator_pkg::*;
(
   input  logic       clk,
   input  logic       reset,

   // universal side request
   input  logic       uav_read,
   input  uav_addr_t  uav_address,
   input  uav_burst_t uav_burstcount,

   // responses back into the translator
   output data_t      uav_readdata,
   output logic       uav_readdatavalid,
   output logic       uav_waitrequest
);

   int    seed;
   data_t pending[$];

   initial begin
      seed              = 32'hd67c;
      uav_readdata      = '0;
      uav_readdatavalid = 1'b0;
      uav_waitrequest   = 1'b0;
   end

   // ------------------------------------------------------------------------
   // accepted read bursts
   // ------------------------------------------------------------------------
   // every word of the burst returns its own byte address as data
   always @(posedge clk) begin : accept_reads
      int i;
      if (reset) begin
         pending.delete();
      end else if (uav_read && !uav_waitrequest) begin
         for (i = 0; i < int'(uav_burstcount) / SYMBOLS_PER_WORD; i++) begin
            pending.push_back(data_t'(uav_address) + data_t'(i * SYMBOLS_PER_WORD));
         end
      end
   end

   // ------------------------------------------------------------------------
   // waitrequest and read data return, driven on the falling edge
   // ------------------------------------------------------------------------
   always @(negedge clk) begin
      // stall roughly one cycle in three
      uav_waitrequest = (({$random(seed)} % 3) == 0);
      // return queued words in order with random gaps
      if (pending.size() > 0 && ({$random(seed)} % 4) != 0) begin
         uav_readdatavalid = 1'b1;
         uav_readdata      = pending.pop_front();
      end else begin
         uav_readdatavalid = 1'b0;
      end
   end

endmodule

/* verif/tb_master_translator.sv */
`timescale 1ns/1ps

module tb_master_translator
   import translator_pkg::*;
();

   // run length, the watchdog limit is derived from it
   localparam int NUM_TRANSACTIONS = 68;
   localparam int MAX_BURST        = 8;
   localparam int CLOCK_PERIOD     = 8;

   logic       clk = 1'b0;
   logic       reset;
   logic       av_read;
   logic       av_write;
   av_addr_t   av_address;
   av_burst_t  av_burstcount;
   byteen_t    av_byteenable;
   data_t      av_writedata;
   data_t      av_readdata;
   logic       av_readdatavalid;
   logic       av_waitrequest;
   logic       uav_read;
   logic       uav_write;
   uav_addr_t  uav_address;
   uav_burst_t uav_burstcount;
   byteen_t    uav_byteenable;
   data_t      uav_writedata;
   data_t      uav_readdata;
   logic       uav_readdatavalid;
   logic       uav_waitrequest;

   int seed;
   int errors          = 0;
   int misses          = 0;
   int writes_accepted = 0;
   int write_stalls    = 0;
   int reads_accepted  = 0;
   int words_returned  = 0;

   // reference of the write burst in progress
   logic       ref_inside;
   av_addr_t   ref_base;
   int         ref_len;
   int         ref_beat;
   uav_addr_t  req_address;
   uav_burst_t req_count;
   uav_addr_t  exp_address;
   uav_burst_t exp_count;

   // expected read words in return order
   data_t      read_expect [256];
   logic [7:0] rd_wr = '0;
   logic [7:0] rd_rd = '0;
   logic       read_pending;
   data_t      exp_readdata;

   master_translator UUT (
      .clk               (clk),
      .reset             (reset),
      .av_read           (av_read),
      .av_write          (av_write),
      .av_address        (av_address),
      .av_burstcount     (av_burstcount),
      .av_byteenable     (av_byteenable),
      .av_writedata      (av_writedata),
      .av_readdata       (av_readdata),
      .av_readdatavalid  (av_readdatavalid),
      .av_waitrequest    (av_waitrequest),
      .uav_read          (uav_read),
      .uav_write         (uav_write),
      .uav_address       (uav_address),
      .uav_burstcount    (uav_burstcount),
      .uav_byteenable    (uav_byteenable),
      .uav_writedata     (uav_writedata),
      .uav_readdata      (uav_readdata),
      .uav_readdatavalid (uav_readdatavalid),
      .uav_waitrequest   (uav_waitrequest)
   );

   tb_slave_model slave (
      .clk               (clk),
      .reset             (reset),
      .uav_read          (uav_read),
      .uav_address       (uav_address),
      .uav_burstcount    (uav_burstcount),
      .uav_readdata      (uav_readdata),
      .uav_readdatavalid (uav_readdatavalid),
      .uav_waitrequest   (uav_waitrequest)
   );

   initial begin
      forever begin
         #(CLOCK_PERIOD / 2) clk = ~clk;
      end
   end

   // ------------------------------------------------------------------------
   // reference counters, fed by accepted transfers on the master side
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ref_inside <= 1'b0;
         ref_base   <= '0;
         ref_len    <= 0;
         ref_beat   <= 0;
      end else if (av_write && !av_waitrequest) begin
         if (!ref_inside) begin
            ref_base   <= av_address;
            ref_len    <= int'(av_burstcount);
            ref_beat   <= 1;
            ref_inside <= (av_burstcount > 1);
         end else begin
            ref_beat   <= ref_beat + 1;
            ref_inside <= (ref_beat + 1 < ref_len);
         end
      end
   end

   always @(posedge clk) begin : read_tracking
      int i;
      if (!reset && av_read && !av_waitrequest) begin
         for (i = 0; i < int'(av_burstcount); i++) begin
            read_expect[rd_wr + 8'(i)] <= data_t'(av_address) * data_t'(SYMBOLS_PER_WORD)
                                        + data_t'(i * SYMBOLS_PER_WORD);
         end
         rd_wr          <= rd_wr + 8'(av_burstcount);
         reads_accepted <= reads_accepted + 1;
      end
      if (!reset && av_readdatavalid) begin
         rd_rd          <= rd_rd + 8'd1;
         words_returned <= words_returned + 1;
      end
      if (!reset && av_write) begin
         if (av_waitrequest) begin
            write_stalls <= write_stalls + 1;
         end else begin
            writes_accepted <= writes_accepted + 1;
         end
      end
   end

   // first beat takes the master request, later beats step by one word
   always_comb begin
      req_address = uav_addr_t'(av_address) * uav_addr_t'(SYMBOLS_PER_WORD);
      req_count   = uav_burst_t'(av_burstcount) * uav_burst_t'(SYMBOLS_PER_WORD);
      if (ref_inside) begin
         exp_address = uav_addr_t'(ref_base) * uav_addr_t'(SYMBOLS_PER_WORD)
                     + uav_addr_t'(ref_beat * SYMBOLS_PER_WORD);
         exp_count   = uav_burst_t'((ref_len - ref_beat) * SYMBOLS_PER_WORD);
      end else begin
         exp_address = req_address;
         exp_count   = req_count;
      end
   end

   assign read_pending = (rd_rd != rd_wr);
   assign exp_readdata = read_expect[rd_rd];

   // ------------------------------------------------------------------------
   // checks
   // ------------------------------------------------------------------------
   a_control_follow : assert property (@(posedge clk) disable iff (reset)
      (uav_write == av_write) && (uav_read == av_read))
      else begin
         errors++;
         $display("FAILED at %0t: universal read or write differs from the master", $time);
      end

   a_write_beat : assert property (@(posedge clk) disable iff (reset)
      uav_write |-> (uav_address == exp_address) && (uav_burstcount == exp_count))
      else begin
         errors++;
         $display("FAILED at %0t: write beat at %h count %0d, expected %h count %0d",
                  $time, $sampled(uav_address), $sampled(uav_burstcount),
                  $sampled(exp_address), $sampled(exp_count));
      end

   a_write_data : assert property (@(posedge clk) disable iff (reset)
      uav_write |-> (uav_writedata == av_writedata) && (uav_byteenable == av_byteenable))
      else begin
         errors++;
         $display("FAILED at %0t: write data or byte enables altered", $time);
      end

   a_stall_hold : assert property (@(posedge clk) disable iff (reset)
      (uav_write && uav_waitrequest) |=> $stable(uav_address) && $stable(uav_burstcount))
      else begin
         errors++;
         $display("FAILED at %0t: address or burst count moved during a stall", $time);
      end

   a_wait_follow : assert property (@(posedge clk) disable iff (reset)
      av_waitrequest == uav_waitrequest)
      else begin
         errors++;
         $display("FAILED at %0t: av_waitrequest differs from uav_waitrequest", $time);
      end

   a_read_request : assert property (@(posedge clk) disable iff (reset)
      uav_read |-> (uav_address == req_address) && (uav_burstcount == req_count))
      else begin
         errors++;
         $display("FAILED at %0t: read at %h count %0d, expected %h count %0d",
                  $time, $sampled(uav_address), $sampled(uav_burstcount),
                  $sampled(req_address), $sampled(req_count));
      end

   a_read_data : assert property (@(posedge clk) disable iff (reset)
      av_readdatavalid |-> read_pending && (av_readdata == exp_readdata))
      else begin
         errors++;
         $display("FAILED at %0t: read word %h, expected %h (pending %0b)", $time,
                  $sampled(av_readdata), $sampled(exp_readdata), $sampled(read_pending));
      end

   // ------------------------------------------------------------------------
   // stimulus helpers, entered and left on a falling edge
   // ------------------------------------------------------------------------
   function automatic int random_length();
      return 1 + int'({$random(seed)} % MAX_BURST);
   endfunction

   function automatic av_addr_t random_address();
      return av_addr_t'($random(seed));
   endfunction

   task automatic wait_accept();
      logic stalled;
      stalled = 1'b1;
      while (stalled) begin
         @(posedge clk);
         stalled = av_waitrequest;
         @(negedge clk);
      end
   endtask

   task automatic write_burst(input av_addr_t address, input int length);
      int beat;
      av_write      = 1'b1;
      av_address    = address;
      av_burstcount = av_burst_t'(length);
      for (beat = 0; beat < length; beat++) begin
         av_writedata  = data_t'($random(seed));
         av_byteenable = byteen_t'($random(seed));
         wait_accept();
      end
      av_write = 1'b0;
   endtask

   task automatic read_burst(input av_addr_t address, input int length);
      av_read       = 1'b1;
      av_address    = address;
      av_burstcount = av_burst_t'(length);
      wait_accept();
      av_read = 1'b0;
   endtask

   task automatic drain_reads();
      while (read_pending) begin
         @(negedge clk);
      end
   endtask

   task automatic report_test(input string name);
      $display("%s finished at %0t ns, failures so far %0d", name, $time, errors + misses);
   endtask

   // ------------------------------------------------------------------------
   // tests
   // ------------------------------------------------------------------------
   initial begin : stimulus
      int stalls_before;
      seed          = 32'hd67c;
      reset         = 1'b1;
      av_read       = 1'b0;
      av_write      = 1'b0;
      av_address    = '0;
      av_burstcount = av_burst_t'(1);
      av_byteenable = '0;
      av_writedata  = '0;
      repeat (5) @(negedge clk);
      reset = 1'b0;

      repeat (8) write_burst(random_address(), 1);
      report_test("single-word writes");

      repeat (20) write_burst(random_address(), random_length());
      report_test("write bursts");

      stalls_before = write_stalls;
      repeat (10) write_burst(random_address(), MAX_BURST);
      if (write_stalls == stalls_before) begin
         misses++;
         $display("no write beat was ever stalled so the stall checks never ran");
      end
      report_test("write stalls");

      repeat (12) read_burst(random_address(), random_length());
      drain_reads();
      report_test("read bursts");

      // bursts follow each other with no idle cycle in between
      repeat (16) begin
         if (({$random(seed)} % 2) == 0) begin
            write_burst(random_address(), random_length());
         end else begin
            read_burst(random_address(), random_length());
         end
      end
      drain_reads();

      // cut a write burst short with a reset after two beats
      av_write      = 1'b1;
      av_address    = random_address();
      av_burstcount = av_burst_t'(6);
      repeat (2) begin
         av_writedata = data_t'($random(seed));
         wait_accept();
      end
      av_write = 1'b0;
      reset    = 1'b1;
      repeat (3) @(negedge clk);
      reset = 1'b0;
      write_burst(random_address(), MAX_BURST);
      repeat (4) @(negedge clk);
      report_test("mixed traffic and reset");

      $display("summary: %0d write beats, %0d stalls, %0d reads, %0d read words, %0d failures",
               writes_accepted, write_stalls, reads_accepted, words_returned, errors + misses);
      if (errors + misses == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

   // watchdog
   initial begin
      #(NUM_TRANSACTIONS * MAX_BURST * 20 * CLOCK_PERIOD);
      $display("timeout: the run did not finish within %0d ns",
               NUM_TRANSACTIONS * MAX_BURST * 20 * CLOCK_PERIOD);
      $display("Test FAILED");
      $finish;
   end

endmodule

/* tb.f */
source/translator_pkg.sv
source/transfer_framer.sv
source/beat_address.sv
source/burst_counter.sv
source/master_translator.sv
verif/tb_slave_model.sv
verif/tb_master_translator.sv

/* Makefile */
# Verilator build and run of the master translator testbench
# every variable below can be overridden on the make command line

VERILATOR ?= verilator
TOP       ?= tb_master_translator
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Test OK

.PHONY: sim clean

# build, run into the log, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
